// ==== rv_decode.f ====
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/instr_mapper.sv
hdl/control_rom.sv
hdl/rv_decode_top.sv
test/rv_decode_assertions.sv
test/rv_decode_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module rv_decode_tb --Mdir obj_dir -f rv_decode.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vrv_decode_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

echo "Simulation finished with status 0"
exit 0

// ==== test/rv_decode_trace.txt ====
# instr    ctrl_word  illegal   (all hex, text after the third column is ignored)
# ctrl_word = {mret, reg_write, mem_to_reg, mem_read, mem_write, alu_op, alu_src, rw_sel, branch, jump}
002081b3 1050 0  add
402081b3 10d0 0  sub
002091b3 1090 0  sll
0020a1b3 1110 0  slt
0020b1b3 1130 0  sltu
0020c1b3 1070 0  xor
0020d1b3 10b0 0  srl
4020d1b3 10f0 0  sra
0020e1b3 1030 0  or
0020f1b3 1010 0  and
022081b3 1150 0  mul
0220c1b3 1030 0  div
0220e1b3 1010 0  rem
00508193 1058 0  addi
0050a193 1118 0  slti
0050b193 1138 0  sltiu
0050c193 1078 0  xori
0050e193 1038 0  ori
0050f193 1018 0  andi
00309193 1098 0  slli
0030d193 10b8 0  srli
4030d193 10f8 0  srai
123451b7 1058 0  lui
00001197 1048 0  auipc
010000ef 104d 0  jal
000100e7 105d 0  jalr
00808183 1c58 0  lb
0080a183 1c58 0  lw
0080d183 1c58 0  lhu
0080f183 1c58 0  load with funct3 7
00208423 0258 0  sb
0020a423 0258 0  sw
00208463 00d2 0  beq
0020c463 00d2 0  blt
0020f463 00d2 0  bgeu
300091f3 1070 0  csrrw
3000a1f3 1030 0  csrrs
3000b1f3 1010 0  csrrc
3000d1f3 1078 0  csrrwi
3000e1f3 1038 0  csrrsi
3000f1f3 1018 0  csrrci
30200073 2070 0  mret
022091b3 0000 1  mulh
00000073 0000 1  ecall
0000000f 0000 1  fence
0000005b 0000 1  unknown opcode
40309193 0000 1  slli with funct7 0100000

// ==== test/rv_decode_tb.sv ====
`default_nettype none

module rv_decode_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import ctrl_pkg::*;

    localparam int MAX_WAIT = 20;  // Cycles before any wait gives up

    logic               reset;     // Clock
    logic               rst;
    isa_pkg::instr_t    instr;
    logic               instr_valid;
    logic               mret;
    logic               reg_write;
    logic               mem_to_reg;
    logic               mem_read;
    logic               mem_write;
    alu_op_t            alu_op;
    alu_src_t           alu_src;
    logic               rw_sel;
    logic               branch;
    logic               jump;
    logic               ctrl_valid;
    logic               illegal_instr;
    ctrl_word_t         dut_word;

    logic [31:0]        trace_instr[$];
    ctrl_word_t         trace_word[$];
    logic               trace_ill[$];

    rv_decode_top rv_decode_top_inst (
        .reset         (reset),
        .rst           (rst),
        .instr         (instr),
        .instr_valid   (instr_valid),
        .mret          (mret),
        .reg_write     (reg_write),
        .mem_to_reg    (mem_to_reg),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .alu_op        (alu_op),
        .alu_src       (alu_src),
        .rw_sel        (rw_sel),
        .branch        (branch),
        .jump          (jump),
        .ctrl_valid    (ctrl_valid),
        .illegal_instr (illegal_instr)
    );

    assign dut_word = {mret, reg_write, mem_to_reg, mem_read, mem_write,
                       alu_op, alu_src, rw_sel, branch, jump};

    initial begin
        reset = 1'b0;
        forever #10 reset = ~reset;  // 20 ns period
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: actual 0x%0h, expected 0x%0h", name, actual, expected);
            abort_run("Output mismatch");
        end
    endtask

    // Word compare covers every control field, mret included
    task automatic check_outputs(input ctrl_word_t word, input logic ill, input logic valid);
        check_value("ctrl_valid", 32'(ctrl_valid), 32'(valid));
        check_value("illegal_instr", 32'(illegal_instr), 32'(ill));
        check_value("ctrl_word", 32'(dut_word), 32'(word));
    endtask

    task automatic load_trace();
        int          fd;
        int          count;
        string       line;
        logic [31:0] f_instr;
        logic [31:0] f_word;
        logic [31:0] f_ill;
        fd = $fopen("test/rv_decode_trace.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the trace file test/rv_decode_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                count = $sscanf(line, "%h %h %h", f_instr, f_word, f_ill);
                if (count == 3) begin  // Comment and blank lines fail the scan
                    trace_instr.push_back(f_instr);
                    trace_word.push_back(f_word[13:0]);
                    trace_ill.push_back(f_ill[0]);
                end
            end
            $fclose(fd);
            if (trace_instr.size() == 0) begin
                abort_run("The trace file holds no instruction lines");
            end
        end
    endtask

    // Counts edges until the decode shows up
    task automatic wait_ctrl_valid(output int latency);
        latency = 0;
        do begin
            @(negedge reset);
            latency++;
            if (!ctrl_valid) begin
                instr_valid = 1'b0;  // No second copy while waiting
            end
        end while (!ctrl_valid && latency < MAX_WAIT);
        if (!ctrl_valid) begin
            abort_run("ctrl_valid never rose after an instruction was presented");
        end
    endtask

    initial begin
        int latency;
        rst         = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        void'($urandom(25));
        load_trace();
        instr       = trace_instr[0];  // Live instruction under reset
        instr_valid = 1'b1;

        repeat (8) @(posedge reset);
        @(negedge reset);
        rst         = 1'b0;
        instr_valid = 1'b0;
        check_outputs('0, 1'b0, 1'b0);  // Quiet after reset

        for (int i = 0; i < trace_instr.size(); i++) begin
            instr       = trace_instr[i];
            instr_valid = 1'b1;
            wait_ctrl_valid(latency);
            check_value("latency", 32'(latency), 32'd1);
            check_outputs(trace_word[i], trace_ill[i], 1'b1);
            if ($urandom_range(1, 0) == 1) begin
                instr       = $urandom;  // Garbage under a bubble
                instr_valid = 1'b0;
                @(negedge reset);
                check_outputs('0, 1'b0, 1'b0);
            end
        end

        instr_valid = 1'b0;
        @(negedge reset);
        check_outputs('0, 1'b0, 1'b0);  // Drains to a NOP
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/rv_decode_assertions.sv ====
`default_nettype none

module rv_decode_assertions (
    input logic               reset,
    input logic               rst,
    input logic               instr_valid,
    input logic               mret,
    input logic               reg_write,
    input logic               mem_to_reg,
    input logic               mem_read,
    input logic               mem_write,
    input ctrl_pkg::alu_op_t  alu_op,
    input ctrl_pkg::alu_src_t alu_src,
    input logic               rw_sel,
    input logic               branch,
    input logic               jump,
    input logic               ctrl_valid,
    input logic               illegal_instr
);

    timeunit 1ns;
    timeprecision 1ps;

    import ctrl_pkg::*;

    ctrl_word_t word;  // Outputs packed back into table order

    assign word = {mret, reg_write, mem_to_reg, mem_read, mem_write,
                   alu_op, alu_src, rw_sel, branch, jump};

    // One-cycle latency, bubbles included
    valid_follows: assert property (@(posedge reset) !rst |=> ctrl_valid == $past(instr_valid))
        else $error("ctrl_valid did not follow instr_valid by one cycle");

    illegal_is_nop: assert property (@(posedge reset) illegal_instr |-> word == '0)
        else $error("illegal_instr set with a nonzero control word");

    mem_exclusive: assert property (@(posedge reset) !(mem_read && mem_write))
        else $error("mem_read and mem_write high together");

    // Everything clear the cycle after a reset edge
    reset_clears: assert property (@(posedge reset)
        rst |=> (!ctrl_valid && !illegal_instr && word == '0))
        else $error("outputs not cleared after rst");

endmodule

bind rv_decode_top rv_decode_assertions rv_decode_assertions_inst (.*);

`default_nettype wire

// ==== hdl/rv_decode_top.sv ====
`default_nettype none

module rv_decode_top (
    input  logic                reset,          // Clock
    input  logic                rst,
    input  isa_pkg::instr_t     instr,
    input  logic                instr_valid,
    output logic                mret,
    output logic                reg_write,
    output logic                mem_to_reg,
    output logic                mem_read,
    output logic                mem_write,
    output ctrl_pkg::alu_op_t   alu_op,
    output ctrl_pkg::alu_src_t  alu_src,
    output logic                rw_sel,
    output logic                branch,
    output logic                jump,
    output logic                ctrl_valid,
    output logic                illegal_instr
);

    import ctrl_pkg::*;

    rom_addr_t map_addr;     // Combinational from mapper
    logic      map_illegal;

    instr_mapper instr_mapper_inst (
        .instr    (instr),
        .rom_addr (map_addr),
        .illegal  (map_illegal)
    );

    // Registered stage, drives all outputs
    control_rom control_rom_inst (
        .reset         (reset),
        .rst           (rst),
        .rom_addr      (map_addr),
        .illegal       (map_illegal),
        .instr_valid   (instr_valid),
        .mret          (mret),
        .reg_write     (reg_write),
        .mem_to_reg    (mem_to_reg),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .alu_op        (alu_op),
        .alu_src       (alu_src),
        .rw_sel        (rw_sel),
        .branch        (branch),
        .jump          (jump),
        .ctrl_valid    (ctrl_valid),
        .illegal_instr (illegal_instr)
    );

endmodule

`default_nettype wire

// ==== hdl/control_rom.sv ====
`default_nettype none

module control_rom (
    input  logic                 reset,
    input  logic                 rst,
    input  ctrl_pkg::rom_addr_t  rom_addr,
    input  logic                 illegal,
    input  logic                 instr_valid,
    output logic                 mret,
    output logic                 reg_write,
    output logic                 mem_to_reg,
    output logic                 mem_read,
    output logic                 mem_write,
    output ctrl_pkg::alu_op_t    alu_op,
    output ctrl_pkg::alu_src_t   alu_src,
    output logic                 rw_sel,
    output logic                 branch,
    output logic                 jump,
    output logic                 ctrl_valid,
    output logic                 illegal_instr
);

    import ctrl_pkg::*;

    ctrl_word_t ctrl_q;
    logic       valid_q;
    logic       illegal_q;

    // Word layout {mret, wr, m2r, mrd, mwr} {alu_op} {alu_src} {rw_sel, branch, jump}
    function automatic ctrl_word_t rom_word(input rom_addr_t addr);
        ctrl_word_t word;
        case (addr)
            ADDR_ADD:    word = {5'b01000, ALU_ADD,  SRC_RR, 3'b000};
            ADDR_SUB:    word = {5'b01000, ALU_SUB,  SRC_RR, 3'b000};
            ADDR_AND:    word = {5'b01000, ALU_AND,  SRC_RR, 3'b000};
            ADDR_OR:     word = {5'b01000, ALU_OR,   SRC_RR, 3'b000};
            ADDR_XOR:    word = {5'b01000, ALU_XOR,  SRC_RR, 3'b000};
            ADDR_SLL:    word = {5'b01000, ALU_SLL,  SRC_RR, 3'b000};
            ADDR_SRL:    word = {5'b01000, ALU_SRL,  SRC_RR, 3'b000};
            ADDR_SRA:    word = {5'b01000, ALU_SRA,  SRC_RR, 3'b000};
            ADDR_SLT:    word = {5'b01000, ALU_SLT,  SRC_RR, 3'b000};
            ADDR_SLTU:   word = {5'b01000, ALU_SLTU, SRC_RR, 3'b000};
            // Address add for memory ops
            ADDR_LOAD:   word = {5'b01110, ALU_ADD,  SRC_RI, 3'b000};
            ADDR_STORE:  word = {5'b00001, ALU_ADD,  SRC_RI, 3'b000};
            ADDR_BRANCH: word = {5'b00000, ALU_SUB,  SRC_RR, 3'b010};  // Compare by subtract
            ADDR_ADDI:   word = {5'b01000, ALU_ADD,  SRC_RI, 3'b000};
            ADDR_SLTI:   word = {5'b01000, ALU_SLT,  SRC_RI, 3'b000};
            ADDR_SLTIU:  word = {5'b01000, ALU_SLTU, SRC_RI, 3'b000};
            ADDR_XORI:   word = {5'b01000, ALU_XOR,  SRC_RI, 3'b000};
            ADDR_ORI:    word = {5'b01000, ALU_OR,   SRC_RI, 3'b000};
            ADDR_ANDI:   word = {5'b01000, ALU_AND,  SRC_RI, 3'b000};
            ADDR_SLLI:   word = {5'b01000, ALU_SLL,  SRC_RI, 3'b000};
            ADDR_SRLI:   word = {5'b01000, ALU_SRL,  SRC_RI, 3'b000};
            ADDR_SRAI:   word = {5'b01000, ALU_SRA,  SRC_RI, 3'b000};
            ADDR_LUI:    word = {5'b01000, ALU_ADD,  SRC_RI, 3'b000};
            ADDR_AUIPC:  word = {5'b01000, ALU_ADD,  SRC_PI, 3'b000};
            ADDR_JAL:    word = {5'b01000, ALU_ADD,  SRC_PI, 3'b101};  // Link reg gets pc+4
            ADDR_JALR:   word = {5'b01000, ALU_ADD,  SRC_RI, 3'b101};
            ADDR_MUL:    word = {5'b01000, ALU_MUL,  SRC_RR, 3'b000};
            ADDR_DIV:    word = {5'b01000, ALU_OR,   SRC_RR, 3'b000};  // Divider keyed off 0001
            ADDR_REM:    word = {5'b01000, ALU_AND,  SRC_RR, 3'b000};
            // CSR ops, alu_op gives the write mode
            ADDR_CSRRW:  word = {5'b01000, ALU_XOR,  SRC_RR, 3'b000};
            ADDR_CSRRC:  word = {5'b01000, ALU_AND,  SRC_RR, 3'b000};
            ADDR_CSRRS:  word = {5'b01000, ALU_OR,   SRC_RR, 3'b000};
            ADDR_CSRRWI: word = {5'b01000, ALU_XOR,  SRC_RI, 3'b000};
            ADDR_CSRRSI: word = {5'b01000, ALU_OR,   SRC_RI, 3'b000};
            ADDR_CSRRCI: word = {5'b01000, ALU_AND,  SRC_RI, 3'b000};
            ADDR_MRET:   word = {5'b10000, ALU_XOR,  SRC_RR, 3'b000};  // No writeback
            default:     word = '0;  // Slot 0 and unused 37..63
        endcase
        return word;
    endfunction

    // One-cycle registered read, bubbles become NOPs
    always_ff @(posedge reset) begin
        if (rst) begin
            ctrl_q    <= '0;
            valid_q   <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            valid_q   <= instr_valid;
            illegal_q <= instr_valid & illegal;
            if (instr_valid) begin
                ctrl_q <= rom_word(rom_addr);
            end else begin
                ctrl_q <= '0;
            end
        end
    end

    assign {mret, reg_write, mem_to_reg, mem_read, mem_write,
            alu_op, alu_src, rw_sel, branch, jump} = ctrl_q;

    assign ctrl_valid    = valid_q;
    assign illegal_instr = illegal_q;

endmodule

`default_nettype wire

// ==== hdl/instr_mapper.sv ====
`default_nettype none

module instr_mapper (
    input  isa_pkg::instr_t     instr,
    output ctrl_pkg::rom_addr_t rom_addr,
    output logic                illegal
);

    import isa_pkg::*;
    import ctrl_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Unmatched encodings fall through to slot 0
    always_comb begin
        rom_addr = ADDR_NOP;
        case (opcode)
            OP_LOAD:   rom_addr = ADDR_LOAD;    // Width handled downstream
            OP_STORE:  rom_addr = ADDR_STORE;
            OP_BRANCH: rom_addr = ADDR_BRANCH;  // Condition from funct3 in EX
            OP_LUI:    rom_addr = ADDR_LUI;
            OP_AUIPC:  rom_addr = ADDR_AUIPC;
            OP_JAL:    rom_addr = ADDR_JAL;
            OP_JALR:   rom_addr = ADDR_JALR;

            OP_REG: begin
                case (funct7)
                    F7_BASE: begin
                        case (funct3)
                            F3_ADD:  rom_addr = ADDR_ADD;
                            F3_SLL:  rom_addr = ADDR_SLL;
                            F3_SLT:  rom_addr = ADDR_SLT;
                            F3_SLTU: rom_addr = ADDR_SLTU;
                            F3_XOR:  rom_addr = ADDR_XOR;
                            F3_SR:   rom_addr = ADDR_SRL;
                            F3_OR:   rom_addr = ADDR_OR;
                            F3_AND:  rom_addr = ADDR_AND;
                            default: rom_addr = ADDR_NOP;
                        endcase
                    end
                    F7_ALT: begin
                        // Only SUB and SRA use the alternate encoding
                        case (funct3)
                            F3_ADD:  rom_addr = ADDR_SUB;
                            F3_SR:   rom_addr = ADDR_SRA;
                            default: rom_addr = ADDR_NOP;
                        endcase
                    end
                    F7_MULDIV: begin
                        // MULH*, DIVU, REMU not supported
                        case (funct3)
                            F3_MUL:  rom_addr = ADDR_MUL;
                            F3_DIV:  rom_addr = ADDR_DIV;
                            F3_REM:  rom_addr = ADDR_REM;
                            default: rom_addr = ADDR_NOP;
                        endcase
                    end
                    default: rom_addr = ADDR_NOP;
                endcase
            end

            OP_IMM: begin
                case (funct3)
                    F3_ADD:  rom_addr = ADDR_ADDI;
                    F3_SLT:  rom_addr = ADDR_SLTI;
                    F3_SLTU: rom_addr = ADDR_SLTIU;
                    F3_XOR:  rom_addr = ADDR_XORI;
                    F3_OR:   rom_addr = ADDR_ORI;
                    F3_AND:  rom_addr = ADDR_ANDI;
                    F3_SLL: begin
                        if (funct7 == F7_BASE) begin
                            rom_addr = ADDR_SLLI;
                        end
                    end
                    F3_SR: begin
                        // imm[11:5] picks logical or arithmetic
                        if (funct7 == F7_BASE) begin
                            rom_addr = ADDR_SRLI;
                        end else if (funct7 == F7_ALT) begin
                            rom_addr = ADDR_SRAI;
                        end
                    end
                    default: rom_addr = ADDR_NOP;
                endcase
            end

            OP_SYSTEM: begin
                case (funct3)
                    F3_CSRRW:  rom_addr = ADDR_CSRRW;
                    F3_CSRRS:  rom_addr = ADDR_CSRRS;
                    F3_CSRRC:  rom_addr = ADDR_CSRRC;
                    F3_CSRRWI: rom_addr = ADDR_CSRRWI;
                    F3_CSRRSI: rom_addr = ADDR_CSRRSI;
                    F3_CSRRCI: rom_addr = ADDR_CSRRCI;
                    F3_PRIV: begin
                        // ECALL, EBREAK, WFI stay illegal
                        if (instr == MRET_WORD) begin
                            rom_addr = ADDR_MRET;
                        end
                    end
                    default: rom_addr = ADDR_NOP;
                endcase
            end

            default: rom_addr = ADDR_NOP;  // FENCE, AMO, unknown
        endcase
    end

    // No legal instruction uses slot 0
    assign illegal = (rom_addr == ADDR_NOP);

endmodule

`default_nettype wire

// ==== hdl/ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

    typedef logic [5:0]  rom_addr_t;   // 64 slots, 37 used
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  alu_src_t;
    // mret, reg_write, mem_to_reg, mem_read, mem_write, alu_op, alu_src, rw_sel, branch, jump
    typedef logic [13:0] ctrl_word_t;

    // ALU operation codes
    localparam alu_op_t ALU_AND  = 4'b0000;
    localparam alu_op_t ALU_OR   = 4'b0001;
    localparam alu_op_t ALU_ADD  = 4'b0010;
    localparam alu_op_t ALU_XOR  = 4'b0011;
    localparam alu_op_t ALU_SLL  = 4'b0100;
    localparam alu_op_t ALU_SRL  = 4'b0101;
    localparam alu_op_t ALU_SUB  = 4'b0110;
    localparam alu_op_t ALU_SRA  = 4'b0111;
    localparam alu_op_t ALU_SLT  = 4'b1000;
    localparam alu_op_t ALU_SLTU = 4'b1001;
    localparam alu_op_t ALU_MUL  = 4'b1010;

    // Operand select
    localparam alu_src_t SRC_RR = 2'b10;  // rs1, rs2
    localparam alu_src_t SRC_RI = 2'b11;  // rs1, imm
    localparam alu_src_t SRC_PI = 2'b01;  // pc, imm

    // ROM addresses
    localparam rom_addr_t ADDR_NOP    = 6'd0;   // Also the illegal slot
    localparam rom_addr_t ADDR_ADD    = 6'd1;
    localparam rom_addr_t ADDR_SUB    = 6'd2;
    localparam rom_addr_t ADDR_AND    = 6'd3;
    localparam rom_addr_t ADDR_OR     = 6'd4;
    localparam rom_addr_t ADDR_XOR    = 6'd5;
    localparam rom_addr_t ADDR_SLL    = 6'd6;
    localparam rom_addr_t ADDR_SRL    = 6'd7;
    localparam rom_addr_t ADDR_SRA    = 6'd8;
    localparam rom_addr_t ADDR_SLT    = 6'd9;
    localparam rom_addr_t ADDR_SLTU   = 6'd10;
    localparam rom_addr_t ADDR_LOAD   = 6'd11;
    localparam rom_addr_t ADDR_STORE  = 6'd12;
    localparam rom_addr_t ADDR_BRANCH = 6'd13;
    localparam rom_addr_t ADDR_ADDI   = 6'd14;
    localparam rom_addr_t ADDR_SLTI   = 6'd15;
    localparam rom_addr_t ADDR_SLTIU  = 6'd16;
    localparam rom_addr_t ADDR_XORI   = 6'd17;
    localparam rom_addr_t ADDR_ORI    = 6'd18;
    localparam rom_addr_t ADDR_ANDI   = 6'd19;
    localparam rom_addr_t ADDR_SLLI   = 6'd20;
    localparam rom_addr_t ADDR_SRLI   = 6'd21;
    localparam rom_addr_t ADDR_SRAI   = 6'd22;
    localparam rom_addr_t ADDR_LUI    = 6'd23;
    localparam rom_addr_t ADDR_AUIPC  = 6'd24;
    localparam rom_addr_t ADDR_JAL    = 6'd25;
    localparam rom_addr_t ADDR_JALR   = 6'd26;
    localparam rom_addr_t ADDR_MUL    = 6'd27;
    localparam rom_addr_t ADDR_DIV    = 6'd28;
    localparam rom_addr_t ADDR_REM    = 6'd29;
    localparam rom_addr_t ADDR_CSRRW  = 6'd30;
    localparam rom_addr_t ADDR_CSRRC  = 6'd31;
    localparam rom_addr_t ADDR_CSRRS  = 6'd32;
    localparam rom_addr_t ADDR_CSRRWI = 6'd33;
    localparam rom_addr_t ADDR_CSRRSI = 6'd34;
    localparam rom_addr_t ADDR_CSRRCI = 6'd35;
    localparam rom_addr_t ADDR_MRET   = 6'd36;

endpackage

`default_nettype wire

// ==== hdl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // Instruction field types
    typedef logic [31:0] instr_t;
    typedef logic [6:0]  opcode_t;   // instr[6:0]
    typedef logic [2:0]  funct3_t;   // instr[14:12]
    typedef logic [6:0]  funct7_t;   // instr[31:25]

    // Major opcodes, RV32 base
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_SYSTEM = 7'b1110011;  // CSR and privileged

    // Upper function field
    localparam funct7_t F7_BASE   = 7'b0000000;
    localparam funct7_t F7_ALT    = 7'b0100000;  // SUB, SRA, SRAI
    localparam funct7_t F7_MULDIV = 7'b0000001;  // M extension

    // ALU funct3, shared by OP_REG and OP_IMM
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;    // SRL or SRA by funct7
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // M extension subset
    localparam funct3_t F3_MUL = 3'b000;
    localparam funct3_t F3_DIV = 3'b100;
    localparam funct3_t F3_REM = 3'b110;

    // SYSTEM funct3
    localparam funct3_t F3_PRIV   = 3'b000;  // ECALL, EBREAK, MRET
    localparam funct3_t F3_CSRRW  = 3'b001;
    localparam funct3_t F3_CSRRS  = 3'b010;
    localparam funct3_t F3_CSRRC  = 3'b011;
    localparam funct3_t F3_CSRRWI = 3'b101;
    localparam funct3_t F3_CSRRSI = 3'b110;
    localparam funct3_t F3_CSRRCI = 3'b111;

    localparam instr_t MRET_WORD = 32'h3020_0073;  // Only accepted PRIV encoding

endpackage

`default_nettype wire
